// ==== rtl/mem_req_pkg.sv ====
// Field widths and vector types for memory requests and responses
// Shared by the request interface, the buffer, the issue stage and the top level
package mem_req_pkg;

    // ========================================
    // Field widths
    // ========================================

    // Word address into the 16-word memory
    localparam int ADDR_WIDTH = 4;

    // Tag returned with every response or ack so a source can match it up
    localparam int TAG_WIDTH = 6;

    // One data word
    localparam int DATA_WIDTH = 32;

    // ========================================
    // Field types
    // ========================================

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // ========================================
    // Packed FIFO words
    // ========================================

    // A buffered read is the tag followed by the address
    localparam int RD_ENTRY_BITS = TAG_WIDTH + ADDR_WIDTH;

    // A buffered write carries the data word behind the tag and address
    localparam int WR_ENTRY_BITS = TAG_WIDTH + ADDR_WIDTH + DATA_WIDTH;

endpackage

// ==== rtl/shim_cfg_pkg.sv ====
// Sizing and bypass configuration of the request buffer
// The top level and the buffer take their FIFO depth and threshold from here
package shim_cfg_pkg;

    // Almost-full rises once this many free slots or fewer remain
    localparam int ALMOST_FULL_THRESHOLD = 4;

    // Two extra slots cover the registered flag and the requests in flight
    localparam int FIFO_ENTRIES = ALMOST_FULL_THRESHOLD + 2;

    // Reads may skip an empty FIFO when this is set
    localparam bit RD_BYPASS_EN = 1'b1;

endpackage

// ==== rtl/mem_req_if.sv ====
// Read and write request channels with their almost-full flags
// The source side drives requests and the sink side answers with the flags
`timescale 1ns/1ps

interface mem_req_if;
    import mem_req_pkg::*;

    // Read request channel
    logic  rd_valid;
    addr_t rd_addr;
    tag_t  rd_tag;

    // Write request channel
    logic  wr_valid;
    addr_t wr_addr;
    tag_t  wr_tag;
    data_t wr_data;

    // Flow control back toward the source
    // A source must stop within the threshold once its flag is high
    logic  rd_alm_full;
    logic  wr_alm_full;

    // Side that issues requests
    modport source (
        output rd_valid, rd_addr, rd_tag,
        output wr_valid, wr_addr, wr_tag, wr_data,
        input  rd_alm_full, wr_alm_full
    );

    // Side that takes requests and reports how full it is
    modport sink (
        input  rd_valid, rd_addr, rd_tag,
        input  wr_valid, wr_addr, wr_tag, wr_data,
        output rd_alm_full, wr_alm_full
    );

endinterface

// ==== rtl/req_fifo.sv ====
// Small LUT-style FIFO that shows its head word without a read latency
// The almost-full flag leaves THRESHOLD slots of slack for a source that reacts late
`timescale 1ns/1ps

module req_fifo #(
    parameter int N_DATA_BITS = 32,
    parameter int N_ENTRIES   = 6,
    parameter int THRESHOLD   = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic                   enq_en,
    output logic                   almost_full,

    output logic [N_DATA_BITS-1:0] first,
    input  logic                   deq_en,
    output logic                   not_empty
);

    // Pointer and counter widths follow the depth
    localparam int PTR_BITS = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;
    logic [CNT_BITS-1:0]    count_next;
    logic                   do_deq;

    // The head is always the word under the read pointer
    assign first     = mem[rd_ptr];
    assign not_empty = (count != '0);

    // A dequeue of an empty FIFO is ignored
    assign do_deq = deq_en && not_empty;

    // Occupancy after this cycle's enqueue and dequeue
    always_comb
    begin
        count_next = count;
        if (enq_en && !do_deq)
            count_next = count + 1'b1;
        else if (!enq_en && do_deq)
            count_next = count - 1'b1;
    end

    // Storage is written only on enqueue
    always_ff @(posedge clk)
    begin
        if (enq_en)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= (wr_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_deq)
                rd_ptr <= (rd_ptr == PTR_BITS'(N_ENTRIES - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_next;
            // Flag from the next occupancy so it never lags the FIFO contents
            almost_full <= ((N_ENTRIES - int'(count_next)) <= THRESHOLD);
        end
    end

endmodule

// ==== rtl/shim_buffer_afu.sv ====
// Latency-insensitive buffer between raw request sources and the request consumer
// Heads stay on the buffered side until the consumer dequeues them explicitly
`timescale 1ns/1ps

module shim_buffer_afu #(
    // Lets a read skip the read FIFO when that FIFO is empty
    parameter bit ENABLE_RD_BYPASS = 1'b0
) (
    input  logic       clk,
    input  logic       reset,

    // Unbuffered requests from the source side
    mem_req_if.sink    raw,

    // FIFO heads toward the consumer
    mem_req_if.source  buffered,

    // Consumer takes the head of a channel with these
    input  logic       rd_deq,
    input  logic       wr_deq
);
    import mem_req_pkg::*;
    import shim_cfg_pkg::*;

    // ========================================
    // Read channel
    // ========================================

    logic [RD_ENTRY_BITS-1:0] rd_fifo_first;
    logic                     rd_fifo_not_empty;
    logic                     rd_fifo_enq;
    logic                     rd_fifo_deq;
    tag_t                     rd_first_tag;
    addr_t                    rd_first_addr;

    assign {rd_first_tag, rd_first_addr} = rd_fifo_first;

    generate
        if (ENABLE_RD_BYPASS)
        begin : g_rd_bypass
            // An empty FIFO forwards the raw read in the same cycle
            assign buffered.rd_valid = rd_fifo_not_empty || raw.rd_valid;
            assign buffered.rd_tag   = rd_fifo_not_empty ? rd_first_tag : raw.rd_tag;
            assign buffered.rd_addr  = rd_fifo_not_empty ? rd_first_addr : raw.rd_addr;

            // Store the read unless it was consumed straight through the bypass
            assign rd_fifo_enq = raw.rd_valid && (rd_fifo_not_empty || !rd_deq);
            // A dequeue of a bypassed read must not touch the FIFO
            assign rd_fifo_deq = rd_deq && rd_fifo_not_empty;
        end
        else
        begin : g_rd_fifo_only
            // Every read goes through the FIFO
            assign buffered.rd_valid = rd_fifo_not_empty;
            assign buffered.rd_tag   = rd_first_tag;
            assign buffered.rd_addr  = rd_first_addr;

            assign rd_fifo_enq = raw.rd_valid;
            assign rd_fifo_deq = rd_deq;
        end
    endgenerate

    req_fifo #(
        .N_DATA_BITS (RD_ENTRY_BITS),
        .N_ENTRIES   (FIFO_ENTRIES),
        .THRESHOLD   (ALMOST_FULL_THRESHOLD)
    ) rd_fifo (
        .clk         (clk),
        .reset       (reset),
        .enq_data    ({raw.rd_tag, raw.rd_addr}),
        .enq_en      (rd_fifo_enq),
        .almost_full (raw.rd_alm_full),
        .first       (rd_fifo_first),
        .deq_en      (rd_fifo_deq),
        .not_empty   (rd_fifo_not_empty)
    );

    // ========================================
    // Write channel
    // ========================================

    // Writes always go through the FIFO since a mux on the data word is costly
    logic [WR_ENTRY_BITS-1:0] wr_fifo_first;
    logic                     wr_fifo_not_empty;

    assign buffered.wr_valid = wr_fifo_not_empty;
    assign {buffered.wr_tag, buffered.wr_addr, buffered.wr_data} = wr_fifo_first;

    req_fifo #(
        .N_DATA_BITS (WR_ENTRY_BITS),
        .N_ENTRIES   (FIFO_ENTRIES),
        .THRESHOLD   (ALMOST_FULL_THRESHOLD)
    ) wr_fifo (
        .clk         (clk),
        .reset       (reset),
        .enq_data    ({raw.wr_tag, raw.wr_addr, raw.wr_data}),
        .enq_en      (raw.wr_valid),
        .almost_full (raw.wr_alm_full),
        .first       (wr_fifo_first),
        .deq_en      (wr_deq),
        .not_empty   (wr_fifo_not_empty)
    );

endmodule

// ==== rtl/mem_issue.sv ====
// Small memory that consumes buffered requests through explicit dequeues
// Reads answer with registered data and tag, writes answer with a registered ack
`timescale 1ns/1ps

module mem_issue (
    input  logic               clk,
    input  logic               reset,
    // Holds both dequeues while high
    input  logic               mem_stall,

    mem_req_if.sink            req,

    output logic               rd_deq,
    output logic               wr_deq,

    output logic               rsp_valid,
    output mem_req_pkg::tag_t  rsp_tag,
    output mem_req_pkg::data_t rsp_data,

    output logic               wr_ack_valid,
    output mem_req_pkg::tag_t  wr_ack_tag
);
    import mem_req_pkg::*;

    // One word per address
    data_t mem [2**ADDR_WIDTH];

    // ========================================
    // Dequeue control
    // ========================================

    // Take every head that is present unless the memory is stalled
    assign rd_deq = req.rd_valid && !mem_stall;
    assign wr_deq = req.wr_valid && !mem_stall;

    // Flow control here is the explicit dequeue so the flags stay low
    assign req.rd_alm_full = 1'b0;
    assign req.wr_alm_full = 1'b0;

    // ========================================
    // Memory array and response valids
    // ========================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid    <= 1'b0;
            wr_ack_valid <= 1'b0;
            // Contents start at zero so untouched addresses read back zero
            for (int i = 0; i < 2**ADDR_WIDTH; i++)
                mem[i] <= '0;
        end
        else
        begin
            rsp_valid    <= rd_deq;
            wr_ack_valid <= wr_deq;
            if (wr_deq)
                mem[req.wr_addr] <= req.wr_data;
        end
    end

    // ========================================
    // Response payload
    // ========================================

    // The read samples the array before this edge's write lands
    // so a same-cycle read and write to one address returns the old word
    always_ff @(posedge clk)
    begin
        if (rd_deq)
        begin
            rsp_tag  <= req.rd_tag;
            rsp_data <= mem[req.rd_addr];
        end
        if (wr_deq)
            wr_ack_tag <= req.wr_tag;
    end

endmodule

// ==== rtl/mem_shim_top.sv ====
// Top level of the request buffer and memory
// Plain request ports feed the buffer and the memory returns responses directly
`timescale 1ns/1ps

module mem_shim_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_stall,

    // Read request channel
    input  logic               rd_valid,
    input  mem_req_pkg::addr_t rd_addr,
    input  mem_req_pkg::tag_t  rd_tag,

    // Write request channel
    input  logic               wr_valid,
    input  mem_req_pkg::addr_t wr_addr,
    input  mem_req_pkg::tag_t  wr_tag,
    input  mem_req_pkg::data_t wr_data,

    // Flow control toward the request sources
    output logic               rd_alm_full,
    output logic               wr_alm_full,

    // Read responses and write acks
    output logic               rsp_valid,
    output mem_req_pkg::tag_t  rsp_tag,
    output mem_req_pkg::data_t rsp_data,
    output logic               wr_ack_valid,
    output mem_req_pkg::tag_t  wr_ack_tag
);
    import shim_cfg_pkg::*;

    // Raw requests from the ports and buffered heads toward the memory
    mem_req_if raw_if ();
    mem_req_if buf_if ();

    logic rd_deq;
    logic wr_deq;

    // The ports act as the source of the raw channels
    assign raw_if.rd_valid = rd_valid;
    assign raw_if.rd_addr  = rd_addr;
    assign raw_if.rd_tag   = rd_tag;
    assign raw_if.wr_valid = wr_valid;
    assign raw_if.wr_addr  = wr_addr;
    assign raw_if.wr_tag   = wr_tag;
    assign raw_if.wr_data  = wr_data;

    assign rd_alm_full = raw_if.rd_alm_full;
    assign wr_alm_full = raw_if.wr_alm_full;

    shim_buffer_afu #(
        .ENABLE_RD_BYPASS (RD_BYPASS_EN)
    ) shim_buffer_afu_inst (
        .clk      (clk),
        .reset    (reset),
        .raw      (raw_if.sink),
        .buffered (buf_if.source),
        .rd_deq   (rd_deq),
        .wr_deq   (wr_deq)
    );

    mem_issue mem_issue_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_stall    (mem_stall),
        .req          (buf_if.sink),
        .rd_deq       (rd_deq),
        .wr_deq       (wr_deq),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag)
    );

endmodule

// ==== testbench/mem_shim_properties.sv ====
// Concurrent assertions on the top-level ports of the request buffer and memory
// Bound into the top level, so every simulation of it carries these checks
`timescale 1ns/1ps

module mem_shim_properties (
    input logic               clk,
    input logic               reset,
    input logic               mem_stall,
    input logic               rd_valid,
    input logic               rd_alm_full,
    input logic               wr_alm_full,
    input logic               rsp_valid,
    input mem_req_pkg::data_t rsp_data,
    input logic               wr_ack_valid
);

    // Reads sampled while rd_alm_full is high, saturating at three
    logic [1:0] rd_since_full;

    // Number of assertion failures so far
    int assert_failures = 0;

    always_ff @(posedge clk)
    begin
        if (reset || !rd_alm_full)
            rd_since_full <= '0;
        else if (rd_valid && rd_since_full != 2'd3)
            rd_since_full <= rd_since_full + 1'b1;
    end

    // The cycle after a reset edge shows no valid and no flag
    reset_clears_outputs: assert property (@(posedge clk)
        reset |=> !(rsp_valid || wr_ack_valid || rd_alm_full || wr_alm_full))
        else
        begin
            $error("A valid or flag was high in the cycle after reset");
            assert_failures++;
        end

    // Read data is fully defined whenever it is presented
    rsp_data_known: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> !$isunknown(rsp_data))
        else
        begin
            $error("rsp_data holds X or Z while rsp_valid is high");
            assert_failures++;
        end

    // A stalled memory never drains, so the read flag cannot fall
    rd_full_held_in_stall: assert property (@(posedge clk) disable iff (reset)
        (rd_alm_full && mem_stall && rd_since_full == 2'd3) |=> rd_alm_full)
        else
        begin
            $error("rd_alm_full fell while the memory was stalled");
            assert_failures++;
        end

endmodule

bind mem_shim_top mem_shim_properties mem_shim_properties_inst (
    .clk          (clk),
    .reset        (reset),
    .mem_stall    (mem_stall),
    .rd_valid     (rd_valid),
    .rd_alm_full  (rd_alm_full),
    .wr_alm_full  (wr_alm_full),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .wr_ack_valid (wr_ack_valid)
);

// ==== testbench/tb_checker.sv ====
// Scoreboard for the request buffer top level
// Records every request at the ports and checks responses and acks against a memory model
`timescale 1ns/1ps

module tb_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_valid,
    input  mem_req_pkg::addr_t rd_addr,
    input  mem_req_pkg::tag_t  rd_tag,
    input  logic               wr_valid,
    input  mem_req_pkg::addr_t wr_addr,
    input  mem_req_pkg::tag_t  wr_tag,
    input  mem_req_pkg::data_t wr_data,
    input  logic               rsp_valid,
    input  mem_req_pkg::tag_t  rsp_tag,
    input  mem_req_pkg::data_t rsp_data,
    input  logic               wr_ack_valid,
    input  mem_req_pkg::tag_t  wr_ack_tag,
    output int                 error_count,
    output int                 rsp_count,
    output int                 ack_count,
    output int                 pending
);
    import mem_req_pkg::*;

    // Model of the memory contents as seen by acknowledged writes
    data_t model [2**ADDR_WIDTH];

    // Requests in order of arrival, one queue per field
    tag_t  rd_tag_q [$];
    addr_t rd_addr_q [$];
    tag_t  wr_tag_q [$];
    addr_t wr_addr_q [$];
    data_t wr_data_q [$];

    tag_t  exp_tag;
    data_t exp_data;

    // Expected read data is whatever the last acknowledged write left at the address
    function automatic data_t expected_read(input addr_t addr);
        return model[addr];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        error_count++;
    endtask

    // ========================================
    // Request capture
    // ========================================

    // Inputs change on the falling edge, so they are stable at the rising edge
    always @(posedge clk)
    begin
        if (reset)
        begin
            rd_tag_q.delete();
            rd_addr_q.delete();
            wr_tag_q.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
        end
        else
        begin
            if (rd_valid)
            begin
                rd_tag_q.push_back(rd_tag);
                rd_addr_q.push_back(rd_addr);
            end
            if (wr_valid)
            begin
                wr_tag_q.push_back(wr_tag);
                wr_addr_q.push_back(wr_addr);
                wr_data_q.push_back(wr_data);
            end
        end
    end

    // ========================================
    // Response comparison
    // ========================================

    // Outputs are registered and settle well before the falling edge
    always @(negedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**ADDR_WIDTH; i++)
                model[i] = '0;
            error_count = 0;
            rsp_count   = 0;
            ack_count   = 0;
        end
        else
        begin
            // Reads are compared first since a same-cycle write must not be visible yet
            if (rsp_valid)
            begin
                rsp_count++;
                if (rd_tag_q.size() == 0)
                begin
                    $display("At %0t a read response with tag %0d came with no read pending",
                             $time, rsp_tag);
                    error_count++;
                end
                else
                begin
                    exp_tag  = rd_tag_q.pop_front();
                    exp_data = expected_read(rd_addr_q.pop_front());
                    if (rsp_tag !== exp_tag)
                        report_mismatch("rsp_tag", exp_tag, rsp_tag);
                    if (rsp_data !== exp_data)
                        report_mismatch("rsp_data", exp_data, rsp_data);
                end
            end
            if (wr_ack_valid)
            begin
                ack_count++;
                if (wr_tag_q.size() == 0)
                begin
                    $display("At %0t a write ack with tag %0d came with no write pending",
                             $time, wr_ack_tag);
                    error_count++;
                end
                else
                begin
                    exp_tag = wr_tag_q.pop_front();
                    if (wr_ack_tag !== exp_tag)
                        report_mismatch("wr_ack_tag", exp_tag, wr_ack_tag);
                    model[wr_addr_q.pop_front()] = wr_data_q.pop_front();
                end
            end
        end
        pending = rd_tag_q.size() + wr_tag_q.size();
    end

endmodule

// ==== testbench/tb_mem_shim.sv ====
// Testbench for the request buffer and memory top level
// Runs directed reset, fill, latency and stall phases, then random mixed traffic,
// while the checker compares every response with its model of the memory
`timescale 1ns/1ps

module tb_mem_shim;
    import mem_req_pkg::*;
    import shim_cfg_pkg::*;

    // Longest wait in cycles before a wait loop gives up
    localparam int TIMEOUT       = 2000;
    localparam int RANDOM_CYCLES = 400;

    logic  clk;
    logic  reset;
    logic  mem_stall;
    logic  rd_valid;
    addr_t rd_addr;
    tag_t  rd_tag;
    logic  wr_valid;
    addr_t wr_addr;
    tag_t  wr_tag;
    data_t wr_data;
    logic  rd_alm_full;
    logic  wr_alm_full;
    logic  rsp_valid;
    tag_t  rsp_tag;
    data_t rsp_data;
    logic  wr_ack_valid;
    tag_t  wr_ack_tag;

    int    seed;
    int    tb_errors;
    int    checker_errors;
    int    rsp_checked;
    int    acks_checked;
    int    pending;
    tag_t  rd_tag_next;
    tag_t  wr_tag_next;

    mem_shim_top mem_shim_top_inst (
        .clk          (clk),
        .reset        (reset),
        .mem_stall    (mem_stall),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag),
        .wr_valid     (wr_valid),
        .wr_addr      (wr_addr),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .rd_alm_full  (rd_alm_full),
        .wr_alm_full  (wr_alm_full),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag)
    );

    tb_checker checker_inst (
        .clk          (clk),
        .reset        (reset),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rd_tag       (rd_tag),
        .wr_valid     (wr_valid),
        .wr_addr      (wr_addr),
        .wr_tag       (wr_tag),
        .wr_data      (wr_data),
        .rsp_valid    (rsp_valid),
        .rsp_tag      (rsp_tag),
        .rsp_data     (rsp_data),
        .wr_ack_valid (wr_ack_valid),
        .wr_ack_tag   (wr_ack_tag),
        .error_count  (checker_errors),
        .rsp_count    (rsp_checked),
        .ack_count    (acks_checked),
        .pending      (pending)
    );

    // 10 ns clock period
    always #5 clk = ~clk;

    // ========================================
    // Stimulus helpers
    // ========================================

    // Each read and write gets the next tag so the checker can see the order
    task automatic drive_read(input addr_t addr);
        rd_valid    = 1'b1;
        rd_addr     = addr;
        rd_tag      = rd_tag_next;
        rd_tag_next = rd_tag_next + 1'b1;
    endtask

    task automatic drive_write(input addr_t addr, input data_t data);
        wr_valid    = 1'b1;
        wr_addr     = addr;
        wr_data     = data;
        wr_tag      = wr_tag_next;
        wr_tag_next = wr_tag_next + 1'b1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    // Holds the channel idle while its almost-full flag is high
    task automatic wait_for_room(input bit is_write);
        int cycles;
        cycles = 0;
        while ((is_write ? wr_alm_full : rd_alm_full) && cycles < TIMEOUT)
        begin
            rd_valid = 1'b0;
            wr_valid = 1'b0;
            @(negedge clk);
            cycles++;
        end
        if (is_write ? wr_alm_full : rd_alm_full)
        begin
            $display("Timed out at %0t waiting for the almost-full flag to fall", $time);
            tb_errors++;
        end
    endtask

    // Waits until the checker has no request left without a response or ack
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (pending != 0 && cycles < TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (pending != 0)
        begin
            $display("Timed out at %0t with %0d requests never answered", $time, pending);
            tb_errors++;
        end
        @(negedge clk);
    endtask

    // ========================================
    // Test phases
    // ========================================

    task automatic read_sequence(input int count);
        for (int i = 0; i < count; i++)
        begin
            @(negedge clk);
            wait_for_room(1'b0);
            drive_read(addr_t'(i));
        end
        @(negedge clk);
        rd_valid = 1'b0;
        wait_drained();
    endtask

    task automatic write_all_addresses();
        for (int i = 0; i < 2**ADDR_WIDTH; i++)
        begin
            @(negedge clk);
            wait_for_room(1'b1);
            drive_write(addr_t'(i), data_t'($random(seed)));
        end
        @(negedge clk);
        wr_valid = 1'b0;
        wait_drained();
    endtask

    // Counts rising edges from the drive until the response is seen
    task automatic measure_latency(input bit is_write, input int expected);
        int  edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        if (is_write)
            drive_write(addr_t'(4'hA), 32'h5A5A_0001);
        else
            drive_read(addr_t'(4'h3));
        while (!seen && edges < TIMEOUT)
        begin
            @(negedge clk);
            edges++;
            rd_valid = 1'b0;
            wr_valid = 1'b0;
            seen = is_write ? wr_ack_valid : rsp_valid;
        end
        if (!seen)
        begin
            $display("Timed out at %0t waiting for a single request to complete", $time);
            tb_errors++;
        end
        else if (is_write)
            check_value("wr_ack_valid latency", expected, edges);
        else
            check_value("rsp_valid latency", expected, edges);
        wait_drained();
    endtask

    // Fills both FIFOs under stall until each flag rises, then sends the threshold more
    task automatic fill_under_stall();
        int rd_sent;
        int wr_sent;
        int rd_rise;
        int wr_rise;
        int cycles;
        int rsp_before;
        int ack_before;
        rd_sent    = 0;
        wr_sent    = 0;
        rd_rise    = -1;
        wr_rise    = -1;
        cycles     = 0;
        rsp_before = rsp_checked;
        ack_before = acks_checked;
        mem_stall  = 1'b1;
        while ((rd_rise < 0 || rd_sent < rd_rise + ALMOST_FULL_THRESHOLD ||
                wr_rise < 0 || wr_sent < wr_rise + ALMOST_FULL_THRESHOLD) && cycles < TIMEOUT)
        begin
            // Flags seen here already account for every request sampled so far
            if (rd_alm_full && rd_rise < 0)
                rd_rise = rd_sent;
            if (wr_alm_full && wr_rise < 0)
                wr_rise = wr_sent;
            rd_valid = 1'b0;
            wr_valid = 1'b0;
            if (rd_rise < 0 || rd_sent < rd_rise + ALMOST_FULL_THRESHOLD)
            begin
                drive_read(addr_t'($random(seed)));
                rd_sent++;
            end
            if (wr_rise < 0 || wr_sent < wr_rise + ALMOST_FULL_THRESHOLD)
            begin
                drive_write(addr_t'($random(seed)), data_t'($random(seed)));
                wr_sent++;
            end
            @(negedge clk);
            cycles++;
        end
        rd_valid = 1'b0;
        wr_valid = 1'b0;
        if (rd_rise < 0 || rd_rise > FIFO_ENTRIES - ALMOST_FULL_THRESHOLD)
        begin
            $display("rd_alm_full was still low with only %0d free read slots left",
                     ALMOST_FULL_THRESHOLD);
            tb_errors++;
        end
        if (wr_rise < 0 || wr_rise > FIFO_ENTRIES - ALMOST_FULL_THRESHOLD)
        begin
            $display("wr_alm_full was still low with only %0d free write slots left",
                     ALMOST_FULL_THRESHOLD);
            tb_errors++;
        end
        // Keep the memory stalled a little so the flags are seen to hold
        repeat (4) @(negedge clk);
        mem_stall = 1'b0;
        wait_drained();
        check_value("rsp_valid count after stall", rd_sent, rsp_checked - rsp_before);
        check_value("wr_ack_valid count after stall", wr_sent, acks_checked - ack_before);
    endtask

    // The write head and a bypassed read to the same address issue on one edge
    task automatic read_after_write_same_cycle();
        @(negedge clk);
        drive_write(addr_t'(4'h5), 32'hC0DE_0055);
        @(negedge clk);
        wr_valid = 1'b0;
        drive_read(addr_t'(4'h5));
        @(negedge clk);
        rd_valid = 1'b0;
        wait_drained();
    endtask

    // Few addresses and a random stall make same-address reads and writes common
    task automatic random_traffic(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            mem_stall = (($random(seed) & 3) == 0);
            rd_valid  = 1'b0;
            wr_valid  = 1'b0;
            if (!rd_alm_full && ($random(seed) & 1))
                drive_read(addr_t'($random(seed) & 3));
            if (!wr_alm_full && ($random(seed) & 1))
                drive_write(addr_t'($random(seed) & 3), data_t'($random(seed)));
        end
        @(negedge clk);
        rd_valid  = 1'b0;
        wr_valid  = 1'b0;
        mem_stall = 1'b0;
        wait_drained();
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        seed        = 74;
        tb_errors   = 0;
        rd_tag_next = '0;
        wr_tag_next = '0;
        clk         = 1'b0;
        reset       = 1'b1;
        mem_stall   = 1'b0;
        rd_valid    = 1'b0;
        rd_addr     = '0;
        rd_tag      = '0;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_tag      = '0;
        wr_data     = '0;

        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Everything the top level drives is low straight out of reset
        check_value("rd_alm_full", 1'b0, rd_alm_full);
        check_value("wr_alm_full", 1'b0, wr_alm_full);
        check_value("rsp_valid", 1'b0, rsp_valid);
        check_value("wr_ack_valid", 1'b0, wr_ack_valid);

        // Untouched addresses read back zero
        read_sequence(4);

        write_all_addresses();
        read_sequence(2**ADDR_WIDTH);

        measure_latency(1'b0, 1);
        measure_latency(1'b1, 2);

        fill_under_stall();
        read_after_write_same_cycle();
        random_traffic(RANDOM_CYCLES);

        $display("Errors: %0d checker, %0d testbench, %0d assertions; %0d responses, %0d acks",
                 checker_errors, tb_errors,
                 mem_shim_top_inst.mem_shim_properties_inst.assert_failures,
                 rsp_checked, acks_checked);
        if (checker_errors == 0 && tb_errors == 0 &&
            mem_shim_top_inst.mem_shim_properties_inst.assert_failures == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/mem_req_pkg.sv
rtl/shim_cfg_pkg.sv
rtl/mem_req_if.sv
rtl/req_fifo.sv
rtl/shim_buffer_afu.sv
rtl/mem_issue.sv
rtl/mem_shim_top.sv
testbench/mem_shim_properties.sv
testbench/tb_checker.sv
testbench/tb_mem_shim.sv

// ==== Bender.yml ====
package:
  name: mem_shim

sources:
  - rtl/mem_req_pkg.sv
  - rtl/shim_cfg_pkg.sv
  - rtl/mem_req_if.sv
  - rtl/req_fifo.sv
  - rtl/shim_buffer_afu.sv
  - rtl/mem_issue.sv
  - rtl/mem_shim_top.sv
  - target: simulation
    files:
      - testbench/mem_shim_properties.sv
      - testbench/tb_checker.sv
      - testbench/tb_mem_shim.sv
